//--- src/sync_pkg.sv
package sync_pkg;

  // width of system time in ticks and of ecat time in ns.
  localparam int time_w = 64;

  // signed slew error, saturates beyond this.
  localparam int diff_w = 19;

  // host settings, written by the ecat side.
  typedef struct packed {
    logic              update;          // one-cycle strobe.
    logic [time_w-1:0] ecat_sync_time;  // ns since ecat epoch.
  } sync_settings_t;

  // capture stage to divider stage.
  typedef struct packed {
    logic              start;           // one-cycle pulse.
    logic [time_w-1:0] ecat_sync_time;
  } load_req_t;

  // divider stage to counter stage.
  typedef struct packed {
    logic              valid;      // level, held until next start.
    logic [time_w-1:0] sync_time;  // in local ticks.
  } sync_point_t;

endpackage

//--- src/sync_capture.sv
`timescale 1ns/1ps

module sync_capture (
  input  logic                       CLK,
  input  logic                       rst,
  input  sync_pkg::sync_settings_t   sync_settings,
  input  logic                       ecat_sync,
  input  logic                       sync_point_valid,
  output logic                       sync,
  output logic                       load_pending,
  output sync_pkg::load_req_t        load_req
);

  logic [2:0]                    sync_sr;   // [0] and [1] synchronize.
  logic                          req_start;
  logic [sync_pkg::time_w-1:0]   req_time;

  // sync0 edge detect after the synchronizer flops.
  always_ff @(posedge CLK) begin
    if (rst) begin
      sync_sr <= '0;
      sync    <= 1'b0;
    end else begin
      sync_sr <= {sync_sr[1:0], ecat_sync};
      sync    <= (sync_sr[2:1] == 2'b01);  // one pulse per edge.
    end
  end

  always_ff @(posedge CLK) begin
    if (rst) begin
      req_start    <= 1'b0;
      load_pending <= 1'b0;
    end else begin
      req_start <= sync_settings.update;
      if (sync_settings.update) begin
        load_pending <= 1'b1;  // newer request wins.
      end else if (sync && sync_point_valid) begin
        load_pending <= 1'b0;  // consumed by this sync0.
      end
    end
  end

  // time travels with the start pulse.
  always_ff @(posedge CLK) begin
    if (sync_settings.update) begin
      req_time <= sync_settings.ecat_sync_time;
    end
  end

  assign load_req = '{start: req_start, ecat_sync_time: req_time};

endmodule

//--- src/lap_divider.sv
`timescale 1ns/1ps

module lap_divider #(
  parameter int unsigned sync_base_ns  = 500000,
  parameter int unsigned sync_base_cnt = 20480
) (
  input  logic                  CLK,
  input  logic                  rst,
  input  sync_pkg::load_req_t   load_req,
  output sync_pkg::sync_point_t sync_point
);

  localparam int tw = sync_pkg::time_w;
  localparam logic [tw-1:0] base_ns  = tw'(sync_base_ns);
  localparam logic [tw-1:0] base_cnt = tw'(sync_base_cnt);

  logic [tw-1:0] quo;        // dividend out at top, quotient in at bottom.
  logic [tw-1:0] rem;
  logic [tw:0]   trial;
  logic [tw:0]   trial_sub;
  logic [6:0]    iter_cnt;
  logic          mul_go;
  logic          valid;
  logic [tw-1:0] sync_time;

  assign trial     = {rem, quo[tw-1]};
  assign trial_sub = trial - {1'b0, base_ns};

  // iteration count and result flags.
  always_ff @(posedge CLK) begin
    if (rst) begin
      iter_cnt <= '0;
      mul_go   <= 1'b0;
      valid    <= 1'b0;
    end else if (load_req.start) begin
      iter_cnt <= 7'(tw);  // restarts a running divide.
      mul_go   <= 1'b0;
      valid    <= 1'b0;
    end else begin
      mul_go <= (iter_cnt == 7'd1);
      if (iter_cnt != '0) begin
        iter_cnt <= iter_cnt - 7'd1;
      end
      if (mul_go) begin
        valid <= 1'b1;
      end
    end
  end

  // restoring shift and subtract, one quotient bit per cycle.
  always_ff @(posedge CLK) begin
    if (load_req.start) begin
      quo <= load_req.ecat_sync_time;
      rem <= '0;
    end else if (iter_cnt != '0) begin
      if (!trial_sub[tw]) begin
        rem <= trial_sub[tw-1:0];
        quo <= {quo[tw-2:0], 1'b1};
      end else begin
        rem <= trial[tw-1:0];
        quo <= {quo[tw-2:0], 1'b0};
      end
    end else if (mul_go) begin
      sync_time <= quo * base_cnt;  // laps to ticks.
    end
  end

  assign sync_point = '{valid: valid, sync_time: sync_time};

endmodule

//--- src/sys_time_slew.sv
`timescale 1ns/1ps

module sys_time_slew #(
  parameter int unsigned sync_base_cnt = 20480
) (
  input  logic                        CLK,
  input  logic                        rst,
  input  logic                        sync,
  input  logic                        load_pending,
  input  sync_pkg::sync_point_t       sync_point,
  output logic [sync_pkg::time_w-1:0] sys_time,
  output logic                        skip_one
);

  localparam int tw = sync_pkg::time_w;
  localparam int dw = sync_pkg::diff_w;
  localparam logic [tw-1:0] base_cnt = tw'(sync_base_cnt);

  logic [tw-1:0]        next_sync_time;  // predicted count at next sync0.
  logic [tw-1:0]        sys_time_inc;
  logic signed [tw:0]   err_full;
  logic signed [dw-1:0] err_sat;
  logic signed [dw-1:0] sync_time_diff;
  logic                 load;
  logic                 err_fits;

  assign load         = sync && load_pending && sync_point.valid;
  assign sys_time_inc = sys_time + tw'(1);

  // error seen at this sync0, counter already stepped by one.
  assign err_full = $signed({1'b0, next_sync_time}) - $signed({1'b0, sys_time_inc});

  // top bits all equal to sign means it fits.
  assign err_fits = (&err_full[tw:dw-1]) || !(|err_full[tw:dw-1]);

  always_comb begin
    if (err_fits) begin
      err_sat = err_full[dw-1:0];
    end else if (err_full[tw]) begin
      err_sat = {1'b1, {(dw-1){1'b0}}};  // most negative.
    end else begin
      err_sat = {1'b0, {(dw-1){1'b1}}};  // most positive.
    end
  end

  always_ff @(posedge CLK) begin
    if (rst) begin
      sys_time       <= '0;
      next_sync_time <= '0;
      sync_time_diff <= '0;
      skip_one       <= 1'b0;
    end else begin
      skip_one <= 1'b0;
      if (load) begin
        // jump to the lap result on the first valid sync0.
        sys_time       <= sync_point.sync_time;
        next_sync_time <= sync_point.sync_time + base_cnt;
        sync_time_diff <= '0;
      end else if (sync) begin
        sys_time       <= sys_time_inc;
        next_sync_time <= next_sync_time + base_cnt;
        sync_time_diff <= err_sat;
      end else if (sync_time_diff > 0) begin
        // behind, catch up by double step.
        sys_time       <= sys_time + tw'(2);
        skip_one       <= 1'b1;
        sync_time_diff <= sync_time_diff - dw'(1);
      end else if (sync_time_diff < 0) begin
        // ahead, hold.
        sync_time_diff <= sync_time_diff + dw'(1);
      end else begin
        sys_time <= sys_time_inc;
      end
    end
  end

endmodule

//--- src/sync_timer_top.sv
`timescale 1ns/1ps

module sync_timer_top #(
  parameter int unsigned sync_base_ns  = 500000,
  parameter int unsigned sync_base_cnt = 20480
) (
  input  logic                        CLK,
  input  logic                        rst,
  input  sync_pkg::sync_settings_t    sync_settings,
  input  logic                        ecat_sync,
  output logic [sync_pkg::time_w-1:0] sys_time,
  output logic                        sync,
  output logic                        skip_one
);

  sync_pkg::load_req_t   load_req;
  sync_pkg::sync_point_t sync_point;
  logic                  load_pending;

  sync_capture i_sync_capture (
    .CLK              (CLK),
    .rst              (rst),
    .sync_settings    (sync_settings),
    .ecat_sync        (ecat_sync),
    .sync_point_valid (sync_point.valid),
    .sync             (sync),
    .load_pending     (load_pending),
    .load_req         (load_req)
  );

  lap_divider #(
    .sync_base_ns  (sync_base_ns),
    .sync_base_cnt (sync_base_cnt)
  ) i_lap_divider (
    .CLK        (CLK),
    .rst        (rst),
    .load_req   (load_req),
    .sync_point (sync_point)
  );

  sys_time_slew #(
    .sync_base_cnt (sync_base_cnt)
  ) i_sys_time_slew (
    .CLK          (CLK),
    .rst          (rst),
    .sync         (sync),
    .load_pending (load_pending),
    .sync_point   (sync_point),
    .sys_time     (sys_time),
    .skip_one     (skip_one)
  );

endmodule

//--- testbench/sync_timer_sva.sv
`timescale 1ns/1ps

module sync_timer_sva (
  input logic                        CLK,
  input logic                        rst,
  input logic                        sync,
  input logic                        skip_one,
  input logic [sync_pkg::time_w-1:0] sys_time
);

  // a double step is what skip_one flags.
  assert property (@(posedge CLK) disable iff (rst)
    skip_one |-> sys_time == $past(sys_time) + 64'd2)
    else $error("skip_one high but counter did not rise by two");

  // only a sync0 may reload the counter.
  assert property (@(posedge CLK) disable iff (rst)
    !$past(sync) |-> sys_time >= $past(sys_time))
    else $error("counter moved backward without sync");

endmodule

bind sys_time_slew sync_timer_sva i_sync_timer_sva (
  .CLK      (CLK),
  .rst      (rst),
  .sync     (sync),
  .skip_one (skip_one),
  .sys_time (sys_time)
);

//--- testbench/tb_sync_timer.sv
`timescale 1ns/1ps

module tb_sync_timer;

  localparam int unsigned base_ns_p  = 1000;
  localparam int unsigned base_cnt_p = 64;
  localparam logic [63:0] base_ns    = 64'd1000;
  localparam logic [63:0] base_cnt   = 64'd64;
  localparam longint      err_max    = (longint'(1) <<< (sync_pkg::diff_w - 1)) - 1;
  localparam longint      err_min    = -(longint'(1) <<< (sync_pkg::diff_w - 1));

  logic                        CLK;
  logic                        rst;
  sync_pkg::sync_settings_t    sync_settings;
  logic                        ecat_sync;
  logic [sync_pkg::time_w-1:0] sys_time;
  logic                        sync;
  logic                        skip_one;

  string       op_q[$];
  longint      a_q[$];
  longint      b_q[$];
  longint      c_q[$];
  bit          parsed = 1'b0;
  bit          failed = 1'b0;
  bit          checking = 1'b0;
  longint      since_pulse = 100;
  int          skip_cnt;
  int          hold_cnt;
  logic [63:0] prev_sys;
  logic [63:0] exp_load;

  // reference model state.
  logic [2:0]  m_sr;
  logic        m_sync;
  logic        m_pending;
  logic        m_start;
  logic        m_valid;
  logic        m_load;
  logic [63:0] m_req_time;
  logic [63:0] m_lap;
  logic [63:0] m_sys;
  logic [63:0] m_pred;
  int          m_cnt;
  longint      m_err;
  longint      e;

  sync_timer_top #(
    .sync_base_ns  (base_ns_p),
    .sync_base_cnt (base_cnt_p)
  ) i_sync_timer_top (
    .CLK           (CLK),
    .rst           (rst),
    .sync_settings (sync_settings),
    .ecat_sync     (ecat_sync),
    .sys_time      (sys_time),
    .sync          (sync),
    .skip_one      (skip_one)
  );

  initial begin
    CLK = 1'b0;
    forever #4 CLK = ~CLK;
  end

  task automatic fail_run();
    failed = 1'b1;
    $display("Something failed");
    $fatal(1);
  endtask

  task automatic check_time(input string name, input logic [sync_pkg::time_w-1:0] exp_v,
                            input logic [sync_pkg::time_w-1:0] act_v);
    if (exp_v !== act_v) begin
      $display("ERROR at %0t: %s expected %0d, got %0d", $time, name, exp_v, act_v);
      fail_run();
    end
  endtask

  task automatic check_bit(input string name, input logic exp_v, input logic act_v);
    if (exp_v !== act_v) begin
      $display("ERROR at %0t: %s expected %0b, got %0b", $time, name, exp_v, act_v);
      fail_run();
    end
  endtask

  task automatic check_count(input string name, input int exp_v, input int act_v);
    if (exp_v != act_v) begin
      $display("ERROR at %0t: %s expected %0d, got %0d", $time, name, exp_v, act_v);
      fail_run();
    end
  endtask

  // model steps on the same edge as the DUT, old values first.
  always @(posedge CLK) begin
    if (rst) begin
      m_sr      = '0;
      m_sync    = 1'b0;
      m_pending = 1'b0;
      m_start   = 1'b0;
      m_cnt     = 0;
      m_valid   = 1'b0;
      m_sys     = '0;
      m_pred    = '0;
      m_err     = 0;
      m_load    = 1'b0;
    end else begin
      m_load = m_sync && m_pending && m_valid;
      if (m_load) begin
        m_sys  = m_lap;
        m_pred = m_lap + base_cnt;
        m_err  = 0;
      end else if (m_sync) begin
        m_sys = m_sys + 64'd1;
        e = longint'(m_pred) - longint'(m_sys);
        m_err  = (e > err_max) ? err_max : ((e < err_min) ? err_min : e);
        m_pred = m_pred + base_cnt;
      end else if (m_err > 0) begin
        m_sys = m_sys + 64'd2;
        m_err = m_err - 1;
      end else if (m_err < 0) begin
        m_err = m_err + 1;
      end else begin
        m_sys = m_sys + 64'd1;
      end
      if (sync_settings.update) m_pending = 1'b1;
      else if (m_sync && m_valid) m_pending = 1'b0;
      if (m_start) begin
        m_cnt   = 65;  // divide plus multiply.
        m_valid = 1'b0;
        m_lap   = (m_req_time / base_ns) * base_cnt;
      end else if (m_cnt > 0) begin
        m_cnt = m_cnt - 1;
        if (m_cnt == 0) m_valid = 1'b1;
      end
      m_start = sync_settings.update;
      if (sync_settings.update) m_req_time = sync_settings.ecat_sync_time;
      m_sync = (m_sr[2:1] == 2'b01);
      m_sr   = {m_sr[1:0], ecat_sync};
    end
  end

  // outputs are settled at the falling edge.
  always @(negedge CLK) begin
    if (checking) begin
      if (m_load) check_time("sys_time after load", exp_load, sys_time);
      check_time("sys_time", m_sys, sys_time);
      check_bit("sync", m_sync, sync);
      if (skip_one) skip_cnt++;
      if (sys_time == prev_sys) hold_cnt++;
    end
    prev_sys = sys_time;
  end

  task automatic next_cycle();
    @(posedge CLK);
    sync_settings.update <= 1'b0;
    if (since_pulse == 4) ecat_sync <= 1'b0;
    since_pulse++;
  endtask

  task automatic read_stimulus();
    int    fd;
    int    n;
    string line;
    string op;
    longint a;
    longint b;
    longint c;
    fd = $fopen("testbench/sync_stimulus.txt", "r");
    if (fd == 0) begin
      $display("could not open the stimulus file");
      fail_run();
    end
    while (!$feof(fd)) begin
      line = "";
      n = $fgets(line, fd);
      if (line.len() < 2 || line[0] == "#") continue;
      a = 0;
      b = 0;
      c = 0;
      n = $sscanf(line, "%s %d %d %d", op, a, b, c);
      op_q.push_back(op);
      a_q.push_back(a);
      b_q.push_back(b);
      c_q.push_back(c);
    end
    $fclose(fd);
  endtask

  // watchdog sized from the stimulus.
  initial begin
    longint total;
    wait (parsed);
    total = 200;
    foreach (op_q[i]) total += (op_q[i] == "set") ? 1 : a_q[i];
    #(total * 8);
    $display("timeout: the run did not finish in %0d ns", total * 8);
    fail_run();
  end

  initial begin
    rst = 1'b1;
    ecat_sync = 1'b0;
    sync_settings = '0;
    read_stimulus();
    parsed = 1'b1;
    repeat (4) @(posedge CLK);
    rst <= 1'b0;
    next_cycle();
    checking = 1'b1;
    skip_cnt = 0;
    hold_cnt = 0;
    foreach (op_q[i]) begin
      if (op_q[i] == "set") begin
        check_time("lap value in file", a_q[i] / base_ns * base_cnt, b_q[i]);
        exp_load = b_q[i];
        next_cycle();
        sync_settings <= '{update: 1'b1, ecat_sync_time: a_q[i]};
      end else if (op_q[i] == "pulse") begin
        while (since_pulse < a_q[i] - 1) next_cycle();
        next_cycle();
        check_count("skip cycles", int'(b_q[i]), skip_cnt);
        check_count("hold cycles", int'(c_q[i]), hold_cnt);
        skip_cnt = 0;
        hold_cnt = 0;
        ecat_sync <= 1'b1;
        since_pulse = 0;
      end else begin
        repeat (a_q[i]) next_cycle();
      end
    end
    if (!failed) begin
      $display("Everything OK");
      $finish;
    end else begin
      fail_run();
    end
  end

endmodule

//--- testbench/sync_stimulus.txt
# set   <ecat time ns> <expected load value in ticks>
# pulse <cycles since previous pulse> <skips> <holds>, counts cover the previous period
# idle  <cycles>
set 7500000 480000
idle 80
# first sync0 loads the lap result
pulse 0 0 0
pulse 64 0 0
# early sync0, error of +10
pulse 54 0 0
pulse 64 10 0
# late sync0, error of -6
pulse 70 0 0
pulse 64 0 6
# new set, too close to the next sync0
set 15000000 960000
pulse 20 0 0
# load waits for this pulse
pulse 64 44 0
pulse 64 0 0
idle 10

//--- project.f
src/sync_pkg.sv
src/sync_capture.sv
src/lap_divider.sv
src/sys_time_slew.sv
src/sync_timer_top.sv
testbench/sync_timer_sva.sv
testbench/tb_sync_timer.sv

//--- run_sim.sh
#!/usr/bin/env bash
# builds and runs the testbench with Verilator, from the project root
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -j 0 --top-module tb_sync_timer \
  -f project.f -o sim_tb \
  && ./obj_dir/sim_tb > sim.log 2>&1

grep -q "Everything OK" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
